//--- rtl/fp_pkg.sv
package fp_pkg;

    localparam int FLOAT_W = 32;
    localparam int EXP_W   = 8;
    localparam int MAN_W   = 23;
    localparam int SIG_W   = 24;                // Hidden one included.
    localparam int EXP_MAX = 255;               // Exponent field of infinity.

    localparam logic [1:0] OP_ADD = 2'd0;
    localparam logic [1:0] OP_SUB = 2'd1;

    typedef enum logic [2:0] {
        S_IDLE,
        S_ALIGN,
        S_COMPUTE,
        S_NORM,
        S_PACK
    } ctrl_state_t;

endpackage

//--- rtl/fp_operand_sort.sv
`timescale 1ns/1ps

module fp_operand_sort (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        load_op,
    input  logic [fp_pkg::FLOAT_W-1:0]  float1,
    input  logic [fp_pkg::FLOAT_W-1:0]  float2,
    input  logic [1:0]                  operand,
    output logic [fp_pkg::SIG_W-1:0]    big_sig,
    output logic [fp_pkg::SIG_W-1:0]    small_sig,
    output logic [fp_pkg::EXP_W-1:0]    big_exp,
    output logic [4:0]                  align_shift,
    output logic                        res_sign,
    output logic                        eff_sub,
    output logic                        op_valid
);
    import fp_pkg::*;

    logic                a_big;
    logic                b_sign;
    logic [FLOAT_W-1:0]  big_word;
    logic [FLOAT_W-1:0]  small_word;
    logic [EXP_W-1:0]    exp_diff;

    function automatic logic [SIG_W-1:0] sig_of(input logic [FLOAT_W-1:0] w);
        if (w[MAN_W +: EXP_W] == '0) begin
            return '0;                          // Zero exponent reads as value zero.
        end
        return {1'b1, w[MAN_W-1:0]};
    endfunction

    always_comb begin
        // Exponent sits above fraction, so one compare orders the magnitudes.
        a_big      = float1[FLOAT_W-2:0] >= float2[FLOAT_W-2:0];
        b_sign     = float2[FLOAT_W-1] ^ (operand == OP_SUB);
        big_word   = a_big ? float1 : float2;
        small_word = a_big ? float2 : float1;
        exp_diff   = big_word[MAN_W +: EXP_W] - small_word[MAN_W +: EXP_W];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            align_shift <= '0;
            res_sign    <= 1'b0;
            eff_sub     <= 1'b0;
            op_valid    <= 1'b0;
        end else if (load_op) begin
            align_shift <= (exp_diff >= EXP_W'(SIG_W)) ? 5'(SIG_W) : exp_diff[4:0];
            res_sign    <= a_big ? float1[FLOAT_W-1] : b_sign;
            eff_sub     <= float1[FLOAT_W-1] ^ b_sign;
            op_valid    <= (operand == OP_ADD) || (operand == OP_SUB);
        end
    end

    always_ff @(posedge clk) begin
        if (load_op) begin
            big_sig   <= sig_of(big_word);
            small_sig <= sig_of(small_word);
            big_exp   <= big_word[MAN_W +: EXP_W];
        end
    end

endmodule

//--- rtl/fp_step_counter.sv
`timescale 1ns/1ps

module fp_step_counter (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        cnt_load,
    input  logic        cnt_en,
    input  logic [4:0]  load_value,
    output logic        cnt_zero
);

    logic [4:0] count;
    logic [4:0] count_next;

    always_comb begin
        if (cnt_load) begin
            count_next = load_value;
        end else if (cnt_en) begin
            count_next = count - 5'd1;
        end else begin
            count_next = count;
        end
    end

    // Flags the count as it stands after this cycle, so the controller
    // leaves a phase on its last step.
    assign cnt_zero = (count_next == 5'd0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else begin
            count <= count_next;
        end
    end

    // The controller must never step past the end of a phase.
    a_no_underflow : assert property (
        @(posedge clk) disable iff (!arst_n)
        cnt_en && !cnt_load |-> count != 5'd0
    );

endmodule

//--- rtl/fp_mantissa_datapath.sv
`timescale 1ns/1ps

module fp_mantissa_datapath (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        dp_load,
    input  logic                        align_step,
    input  logic                        compute,
    input  logic                        norm_step,
    input  logic                        pack,
    input  logic                        op_valid,
    input  logic                        res_sign,
    input  logic                        eff_sub,
    input  logic [fp_pkg::SIG_W-1:0]    big_sig,
    input  logic [fp_pkg::SIG_W-1:0]    small_sig,
    input  logic [fp_pkg::EXP_W-1:0]    big_exp,
    output logic                        norm_done,
    output logic                        result_zero,
    output logic [fp_pkg::FLOAT_W-1:0]  float_ans,
    output logic                        overflow
);
    import fp_pkg::*;

    logic [SIG_W-1:0]         small_q;
    logic [SIG_W:0]           sum_q;
    logic [SIG_W:0]           sum_raw;
    logic signed [EXP_W+1:0]  exp_q;            // Two spare bits catch under- and overflow.

    always_comb begin
        if (eff_sub) begin
            sum_raw = {1'b0, big_sig} - {1'b0, small_q};
        end else begin
            sum_raw = {1'b0, big_sig} + {1'b0, small_q};
        end
    end

    assign result_zero = (sum_q == '0);
    assign norm_done   = sum_q[SIG_W-1] || result_zero;

    always_ff @(posedge clk) begin
        if (dp_load) begin
            small_q <= small_sig;
            exp_q   <= signed'({2'b00, big_exp});
        end else if (align_step) begin
            small_q <= small_q >> 1;            // Shifted-out bits are dropped.
        end else if (compute) begin
            if (sum_raw[SIG_W]) begin
                sum_q <= sum_raw >> 1;
                exp_q <= exp_q + 2'sd1;
            end else begin
                sum_q <= sum_raw;
            end
        end else if (norm_step) begin
            sum_q <= {sum_q[SIG_W-1:0], 1'b0};
            exp_q <= exp_q - 2'sd1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            float_ans <= '0;
            overflow  <= 1'b0;
        end else if (pack) begin
            if (!op_valid || result_zero || exp_q <= 0) begin
                float_ans <= '0;                // Flush to +0.
                overflow  <= 1'b0;
            end else if (int'(exp_q) >= EXP_MAX) begin
                float_ans <= {res_sign, EXP_W'(EXP_MAX), {MAN_W{1'b0}}};
                overflow  <= 1'b1;
            end else begin
                float_ans <= {res_sign, exp_q[EXP_W-1:0], sum_q[MAN_W-1:0]};
                overflow  <= 1'b0;
            end
        end
    end

    a_one_shift_dir : assert property (
        @(posedge clk) disable iff (!arst_n)
        !(align_step && norm_step)
    );

    // Normalization must have finished before the word is packed.
    a_packed_normal : assert property (
        @(posedge clk) disable iff (!arst_n)
        pack && !result_zero |-> sum_q[SIG_W-1] && !sum_q[SIG_W]
    );

endmodule

//--- rtl/fp_addsub_ctrl.sv
`timescale 1ns/1ps

module fp_addsub_ctrl (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  start,
    input  logic  cnt_zero,
    input  logic  norm_done,
    output logic  load_op,
    output logic  dp_load,
    output logic  cnt_load,
    output logic  cnt_en,
    output logic  align_step,
    output logic  compute,
    output logic  norm_step,
    output logic  pack,
    output logic  busy,
    output logic  done
);
    import fp_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        load_pend;                     // Operands registered, datapath not yet loaded.

    assign busy    = (state != S_IDLE) || load_pend;
    assign load_op = start && !busy;
    assign dp_load = load_pend;

    always_comb begin
        state_next = state;
        cnt_load   = 1'b0;
        cnt_en     = 1'b0;
        align_step = 1'b0;
        compute    = 1'b0;
        norm_step  = 1'b0;
        pack       = 1'b0;
        case (state)
            S_IDLE: begin
                if (load_pend) begin
                    cnt_load   = 1'b1;
                    state_next = cnt_zero ? S_COMPUTE : S_ALIGN;
                end
            end
            S_ALIGN: begin
                align_step = 1'b1;
                cnt_en     = 1'b1;
                if (cnt_zero) begin
                    state_next = S_COMPUTE;
                end
            end
            S_COMPUTE: begin
                compute    = 1'b1;
                cnt_load   = 1'b1;              // Arms the normalization limit.
                state_next = S_NORM;
            end
            S_NORM: begin
                if (norm_done) begin
                    state_next = S_PACK;
                end else begin
                    norm_step = 1'b1;
                    cnt_en    = 1'b1;
                    if (cnt_zero) begin
                        state_next = S_PACK;
                    end
                end
            end
            S_PACK: begin
                pack       = 1'b1;
                state_next = S_IDLE;
            end
            default: state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= S_IDLE;
            load_pend <= 1'b0;
            done      <= 1'b0;
        end else begin
            state     <= state_next;
            load_pend <= load_op;
            done      <= pack;
        end
    end

    a_done_pulse : assert property (
        @(posedge clk) disable iff (!arst_n)
        done |=> !done
    );

endmodule

//--- rtl/fp_addsub_top.sv
`timescale 1ns/1ps

module fp_addsub_top (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        start,
    input  logic [fp_pkg::FLOAT_W-1:0]  float1,
    input  logic [fp_pkg::FLOAT_W-1:0]  float2,
    input  logic [1:0]                  operand,
    output logic [fp_pkg::FLOAT_W-1:0]  float_ans,
    output logic                        overflow,
    output logic                        busy,
    output logic                        done
);
    import fp_pkg::*;

    logic               load_op;
    logic               dp_load;
    logic               cnt_load;
    logic               cnt_en;
    logic               cnt_zero;
    logic               align_step;
    logic               compute;
    logic               norm_step;
    logic               pack;
    logic               norm_done;
    logic [SIG_W-1:0]   big_sig;
    logic [SIG_W-1:0]   small_sig;
    logic [EXP_W-1:0]   big_exp;
    logic [4:0]         align_shift;
    logic [4:0]         cnt_value;
    logic               res_sign;
    logic               eff_sub;
    logic               op_valid;

    // Load phase takes the shift distance, otherwise the normalization limit.
    assign cnt_value = dp_load ? align_shift : 5'(SIG_W);

    fp_operand_sort fp_operand_sort_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .load_op     (load_op),
        .float1      (float1),
        .float2      (float2),
        .operand     (operand),
        .big_sig     (big_sig),
        .small_sig   (small_sig),
        .big_exp     (big_exp),
        .align_shift (align_shift),
        .res_sign    (res_sign),
        .eff_sub     (eff_sub),
        .op_valid    (op_valid)
    );

    fp_step_counter fp_step_counter_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .cnt_load   (cnt_load),
        .cnt_en     (cnt_en),
        .load_value (cnt_value),
        .cnt_zero   (cnt_zero)
    );

    fp_mantissa_datapath fp_mantissa_datapath_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .dp_load     (dp_load),
        .align_step  (align_step),
        .compute     (compute),
        .norm_step   (norm_step),
        .pack        (pack),
        .op_valid    (op_valid),
        .res_sign    (res_sign),
        .eff_sub     (eff_sub),
        .big_sig     (big_sig),
        .small_sig   (small_sig),
        .big_exp     (big_exp),
        .norm_done   (norm_done),
        .result_zero (),
        .float_ans   (float_ans),
        .overflow    (overflow)
    );

    fp_addsub_ctrl fp_addsub_ctrl_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .cnt_zero   (cnt_zero),
        .norm_done  (norm_done),
        .load_op    (load_op),
        .dp_load    (dp_load),
        .cnt_load   (cnt_load),
        .cnt_en     (cnt_en),
        .align_step (align_step),
        .compute    (compute),
        .norm_step  (norm_step),
        .pack       (pack),
        .busy       (busy),
        .done       (done)
    );

endmodule

//--- test/fp_ref_model.svh
`ifndef FP_REF_MODEL_SVH
`define FP_REF_MODEL_SVH

// Significand with the hidden one; a zero exponent field reads as zero.
function automatic int ref_sig(input logic [FLOAT_W-1:0] w);
    if (w[30:23] == 8'd0) begin
        return 0;
    end
    return int'({1'b1, w[22:0]});
endfunction

// Returns {overflow, result word} for one operation, truncating.
function automatic logic [FLOAT_W:0] ref_addsub(input logic [FLOAT_W-1:0] a,
                                               input logic [FLOAT_W-1:0] b,
                                               input logic [1:0]         op);
    logic sign_a;
    logic sign_b;
    logic sign_r;
    logic b_big;
    int   exp_r;
    int   diff;
    int   sig_big;
    int   sig_small;
    int   sig_r;
    if (op != OP_ADD && op != OP_SUB) begin
        return '0;
    end
    sign_a    = a[31];
    sign_b    = b[31] ^ (op == OP_SUB);
    b_big     = (b[30:23] > a[30:23]) || (b[30:23] == a[30:23] && b[22:0] > a[22:0]);
    sign_r    = b_big ? sign_b : sign_a;
    exp_r     = b_big ? int'(b[30:23]) : int'(a[30:23]);
    diff      = b_big ? exp_r - int'(a[30:23]) : exp_r - int'(b[30:23]);
    sig_big   = b_big ? ref_sig(b) : ref_sig(a);
    sig_small = b_big ? ref_sig(a) : ref_sig(b);
    sig_small = (diff >= 24) ? 0 : sig_small >> diff;
    sig_r     = (sign_a != sign_b) ? sig_big - sig_small : sig_big + sig_small;
    if (sig_r == 0) begin
        return '0;                              // Exact zero is +0.
    end
    if (sig_r >= (1 << 24)) begin
        sig_r = sig_r >> 1;
        exp_r = exp_r + 1;
    end
    while (sig_r < (1 << 23)) begin
        sig_r = sig_r << 1;
        exp_r = exp_r - 1;
    end
    if (exp_r <= 0) begin
        return '0;
    end
    if (exp_r >= 255) begin
        return {1'b1, sign_r, 8'hff, 23'd0};
    end
    return {1'b0, sign_r, exp_r[7:0], sig_r[22:0]};
endfunction

`endif

//--- test/fp_addsub_tb.sv
`timescale 1ns/1ps

module fp_addsub_tb;
    import fp_pkg::*;

    localparam int          OP_COUNT    = 230;
    localparam int          CYCLE_LIMIT = OP_COUNT * 40 + 100;
    localparam logic [31:0] RAND_SEED   = 32'h010aea9c;

    logic               clk;
    logic               arst_n;
    logic               start;
    logic [FLOAT_W-1:0] float1;
    logic [FLOAT_W-1:0] float2;
    logic [1:0]         operand;
    logic [FLOAT_W-1:0] float_ans;
    logic               overflow;
    logic               busy;
    logic               done;
    int                 cycle_count = 0;

    `include "fp_ref_model.svh"

    fp_addsub_top fp_addsub_top_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .float1    (float1),
        .float2    (float2),
        .operand   (operand),
        .float_ans (float_ans),
        .overflow  (overflow),
        .busy      (busy),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Verification failed");
            $fatal(1, "Timeout: no result after %0d cycles.", CYCLE_LIMIT);
        end
    end

    task automatic check_value(input string name, input logic [FLOAT_W-1:0] expected,
                               input logic [FLOAT_W-1:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            $display("Verification failed");
            $fatal(1, "Wrong value in test %s.", name);
        end
    endtask

    // One-cycle start strobe, 1 ns after the edge.
    task automatic drive_start(input logic [FLOAT_W-1:0] a, input logic [FLOAT_W-1:0] b,
                               input logic [1:0] op);
        @(posedge clk);
        #1;
        start   = 1'b1;
        float1  = a;
        float2  = b;
        operand = op;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_done();
        while (done !== 1'b1) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_op(input string name, input logic [FLOAT_W-1:0] a,
                          input logic [FLOAT_W-1:0] b, input logic [1:0] op);
        logic [FLOAT_W:0] expected;
        expected = ref_addsub(a, b, op);
        drive_start(a, b, op);
        wait_done();
        check_value(name, expected[FLOAT_W-1:0], float_ans);
        check_value({name, " overflow"}, 32'(expected[FLOAT_W]), 32'(overflow));
        check_value({name, " busy"}, 32'd0, 32'(busy));
    endtask

    task automatic add_test();
        run_op("add carry", 32'h3fc00000, 32'h3fc00000, OP_ADD);
        run_op("add diff exp", 32'h3f800000, 32'h40000000, OP_ADD);
        run_op("add small", 32'h40400000, 32'h3f000000, OP_ADD);
        run_op("add negative", 32'hbfc00000, 32'hc0000000, OP_ADD);
    endtask

    task automatic sub_test();
        run_op("sub positive", 32'h40400000, 32'h3f800000, OP_SUB);
        run_op("sub negative", 32'h3f800000, 32'h40400000, OP_SUB);
        run_op("sub equal", 32'hc0000000, 32'hc0000000, OP_SUB);
        run_op("add opposite", 32'h3f800000, 32'hbf800000, OP_ADD);
        run_op("sub mixed", 32'hbfc00000, 32'h3f000000, OP_SUB);
    endtask

    task automatic far_and_zero_test();
        run_op("diff 30", 32'h3f800000, 32'h30800000, OP_ADD);
        run_op("diff 24", 32'h33800000, 32'h3f800000, OP_SUB);
        run_op("zero plus", 32'h00000000, 32'h40000000, OP_ADD);
        run_op("minus zero", 32'hc0400000, 32'h00000000, OP_SUB);
    endtask

    task automatic range_edge_test();
        run_op("cancel long", 32'h3f800001, 32'h3f800000, OP_SUB);
        run_op("flush lsb", 32'h00800001, 32'h00800000, OP_SUB);
        run_op("flush half", 32'h00c00000, 32'h00800000, OP_SUB);
        run_op("overflow pos", 32'h7f7fffff, 32'h7f7fffff, OP_ADD);
        run_op("overflow neg", 32'hff7fffff, 32'h7f7fffff, OP_SUB);
    endtask

    task automatic unused_op_and_busy_test();
        logic [FLOAT_W:0] expected;
        run_op("op code 2", 32'h3f800000, 32'h40000000, 2'd2);
        run_op("op code 3", 32'h3f800000, 32'h40000000, 2'd3);
        expected = ref_addsub(32'h3fc00000, 32'h3f800000, OP_ADD);
        drive_start(32'h3fc00000, 32'h3f800000, OP_ADD);
        check_value("busy raised", 32'd1, 32'(busy));
        start   = 1'b1;                         // Must be ignored.
        float1  = 32'h40400000;
        float2  = 32'h40000000;
        operand = OP_SUB;
        @(posedge clk);
        #1;
        start = 1'b0;
        wait_done();
        check_value("start while busy", expected[FLOAT_W-1:0], float_ans);
        @(posedge clk);
        #1;
        check_value("done pulse", 32'd0, 32'(done));
        check_value("idle after", 32'd0, 32'(busy));
    endtask

    task automatic random_test();
        logic [FLOAT_W-1:0] a;
        logic [FLOAT_W-1:0] b;
        logic [1:0]         op;
        int                 exp_a;
        int                 exp_b;
        int                 i;
        for (i = 0; i < 200; i++) begin
            exp_a = int'($urandom_range(254, 1));
            exp_b = exp_a + int'($urandom_range(60, 0)) - 30;   // Mostly close exponents.
            if (exp_b < 1) begin
                exp_b = 1;
            end
            if (exp_b > 254) begin
                exp_b = 254;
            end
            a  = {1'($urandom_range(1, 0)), exp_a[7:0], 23'($urandom())};
            b  = {1'($urandom_range(1, 0)), exp_b[7:0], 23'($urandom())};
            op = ($urandom_range(1, 0) == 1) ? OP_SUB : OP_ADD;
            run_op("random", a, b, op);
        end
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        arst_n  = 1'b0;
        start   = 1'b0;
        float1  = '0;
        float2  = '0;
        operand = OP_ADD;
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_value("reset result", 32'd0, float_ans);
        check_value("reset flags", 32'd0, 32'({overflow, busy, done}));
        add_test();
        sub_test();
        far_and_zero_test();
        range_edge_test();
        unused_op_and_busy_test();
        random_test();
        $display("Verification passed");
        $finish;
    end

endmodule

//--- all.f
+incdir+test
rtl/fp_pkg.sv
rtl/fp_operand_sort.sv
rtl/fp_step_counter.sv
rtl/fp_mantissa_datapath.sv
rtl/fp_addsub_ctrl.sv
rtl/fp_addsub_top.sv
test/fp_addsub_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f all.f \
    --top-module fp_addsub_tb \
    -Mdir build/obj_dir

./build/obj_dir/Vfp_addsub_tb
